//--- hdl/pipe_config.svh
`ifndef PIPE_CONFIG_SVH
`define PIPE_CONFIG_SVH

// datapath and instruction word width
`define DATA_W 16
// register index width, eight registers
`define REG_ADDR_W 3
`define NUM_REGS (1 << `REG_ADDR_W)
// external data memory address, low bits of base plus offset
`define MEM_ADDR_W 8

`endif

//--- hdl/pipePkg.sv
`default_nettype none

package pipePkg;

    // opcode field, instr[15:12]
    // unlisted codes decode as nop
    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,
        OP_ADD  = 4'h1,
        OP_SUB  = 4'h2,
        OP_AND  = 4'h3,
        OP_XOR  = 4'h4,
        OP_ADDI = 4'h5,
        OP_LBI  = 4'h6,
        OP_ST   = 4'h7
    } opcodeT;

    // alu function carried down the pipe
    typedef enum logic [1:0] {
        ALU_ADD = 2'b00,
        ALU_SUB = 2'b01,
        ALU_AND = 2'b10,
        ALU_XOR = 2'b11
    } aluOpT;

    // operand source for EX
    // 2'b11 is never produced
    typedef enum logic [1:0] {
        FWD_NONE  = 2'b00,
        FWD_MEMWB = 2'b01,
        FWD_EXMEM = 2'b10
    } fwdSelT;

endpackage

`default_nettype wire

//--- hdl/pipeControl.sv
`default_nettype none
`include "pipe_config.svh"

module pipeControl
    import pipePkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   arstN,
    input  wire logic                   instrValid,
    input  wire logic [`DATA_W-1:0]     instr,
    output logic [`REG_ADDR_W-1:0]      readIdxA,
    output logic [`REG_ADDR_W-1:0]      readIdxB,
    output logic [`REG_ADDR_W-1:0]      idexRs,
    output logic [`REG_ADDR_W-1:0]      idexRt,
    output aluOpT                       idexAluOp,
    output logic                        idexUseImm,
    output logic                        idexImmOnly,
    output logic [`DATA_W-1:0]          idexImm,
    output logic                        exmemRegWrite,
    output logic                        exmemMemWrite,
    output logic [`REG_ADDR_W-1:0]      exmemRd,
    output logic                        memwbRegWrite,
    output logic                        memwbMemWrite,
    output logic [`REG_ADDR_W-1:0]      memwbRd,
    output logic                        memWrite,
    output logic                        wbValid,
    output logic [`REG_ADDR_W-1:0]      wbReg
);

    opcodeT                  decOp;
    logic                    decRegWrite;
    logic                    decMemWrite;
    aluOpT                   decAluOp;
    logic                    decUseImm;
    logic                    decImmOnly;
    logic [`DATA_W-1:0]      decImm;

    logic                    idexValid;
    logic                    idexRegWrite;
    logic                    idexMemWrite;
    logic [`REG_ADDR_W-1:0]  idexRd;
    logic                    exmemValid;
    logic                    memwbValid;

    // bubble or unknown opcode becomes nop
    always_comb begin
        decOp = OP_NOP;
        if (instrValid && (instr[15:12] inside {OP_ADD, OP_SUB, OP_AND, OP_XOR,
                                               OP_ADDI, OP_LBI, OP_ST})) begin
            decOp = opcodeT'(instr[15:12]);
        end
    end

    always_comb begin
        decRegWrite = 1'b0;
        decMemWrite = 1'b0;
        decAluOp    = ALU_ADD;
        decUseImm   = 1'b0;
        decImmOnly  = 1'b0;
        case (decOp)
            OP_ADD:  decRegWrite = 1'b1;
            OP_SUB: begin
                decRegWrite = 1'b1;
                decAluOp    = ALU_SUB;
            end
            OP_AND: begin
                decRegWrite = 1'b1;
                decAluOp    = ALU_AND;
            end
            OP_XOR: begin
                decRegWrite = 1'b1;
                decAluOp    = ALU_XOR;
            end
            OP_ADDI: begin
                decRegWrite = 1'b1;
                decUseImm   = 1'b1;
            end
            // imm passes straight through the adder
            OP_LBI: begin
                decRegWrite = 1'b1;
                decUseImm   = 1'b1;
                decImmOnly  = 1'b1;
            end
            // alu forms base + offset
            OP_ST: begin
                decMemWrite = 1'b1;
                decUseImm   = 1'b1;
            end
            default: ;
        endcase
    end

    // lbi takes 8 imm bits, addi and st take 6
    assign decImm = (decOp == OP_LBI) ? {{(`DATA_W-8){instr[7]}}, instr[7:0]}
                                      : {{(`DATA_W-6){instr[5]}}, instr[5:0]};

    // register read, st reads its data reg on port B
    assign readIdxA = instr[8:6];
    assign readIdxB = (decOp == OP_ST) ? instr[11:9] : instr[5:3];

    // valid and write enables
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            idexValid     <= 1'b0;
            idexRegWrite  <= 1'b0;
            idexMemWrite  <= 1'b0;
            exmemValid    <= 1'b0;
            exmemRegWrite <= 1'b0;
            exmemMemWrite <= 1'b0;
            memwbValid    <= 1'b0;
            memwbRegWrite <= 1'b0;
            memwbMemWrite <= 1'b0;
        end else begin
            idexValid     <= instrValid;
            idexRegWrite  <= decRegWrite;
            idexMemWrite  <= decMemWrite;
            exmemValid    <= idexValid;
            exmemRegWrite <= idexRegWrite;
            exmemMemWrite <= idexMemWrite;
            memwbValid    <= exmemValid;
            memwbRegWrite <= exmemRegWrite;
            memwbMemWrite <= exmemMemWrite;
        end
    end

    // indices and immediates
    always_ff @(posedge clk) begin
        idexRd      <= instr[11:9];
        idexRs      <= readIdxA;
        idexRt      <= readIdxB;
        idexAluOp   <= decAluOp;
        idexUseImm  <= decUseImm;
        idexImmOnly <= decImmOnly;
        idexImm     <= decImm;
        exmemRd     <= idexRd;
        memwbRd     <= exmemRd;
    end

    // external strobes, one cycle each
    assign memWrite = exmemValid && exmemMemWrite;
    assign wbValid  = memwbValid && memwbRegWrite;
    assign wbReg    = memwbRd;

    // a stage either writes a register or stores, never both
    assert property (@(posedge clk) disable iff (!arstN)
        !(idexRegWrite && idexMemWrite) && !(exmemRegWrite && exmemMemWrite) &&
        !(memwbRegWrite && memwbMemWrite))
        else $error("stage holds both regWrite and memWrite");

endmodule

`default_nettype wire

//--- hdl/regFile.sv
`default_nettype none
`include "pipe_config.svh"

module regFile (
    input  wire logic                    clk,
    input  wire logic                    arstN,
    input  wire logic [`REG_ADDR_W-1:0]  readIdxA,
    input  wire logic [`REG_ADDR_W-1:0]  readIdxB,
    input  wire logic                    writeEn,
    input  wire logic [`REG_ADDR_W-1:0]  writeIdx,
    input  wire logic [`DATA_W-1:0]      writeData,
    output logic [`DATA_W-1:0]           readDataA,
    output logic [`DATA_W-1:0]           readDataB
);

    logic [`DATA_W-1:0] regs [`NUM_REGS];

    // r0 is an ordinary register here
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[writeIdx] <= writeData;
        end
    end

    // write-through bypass
    // covers the producer three slots ahead, still in MEM/WB
    always_comb begin
        readDataA = regs[readIdxA];
        readDataB = regs[readIdxB];
        if (writeEn && (writeIdx == readIdxA)) begin
            readDataA = writeData;
        end
        if (writeEn && (writeIdx == readIdxB)) begin
            readDataB = writeData;
        end
    end

    // MEM/WB rd must be known when its write enable is set
    assert property (@(posedge clk) disable iff (!arstN)
        writeEn |-> !$isunknown(writeIdx))
        else $error("regFile write with unknown index");

endmodule

`default_nettype wire

//--- hdl/forwardingUnit.sv
`default_nettype none
`include "pipe_config.svh"

module forwardingUnit
    import pipePkg::*;
(
    input  wire logic [`REG_ADDR_W-1:0]  idexRs,
    input  wire logic [`REG_ADDR_W-1:0]  idexRt,
    input  wire logic                    exmemRegWrite,
    input  wire logic [`REG_ADDR_W-1:0]  exmemRd,
    input  wire logic                    memwbRegWrite,
    input  wire logic [`REG_ADDR_W-1:0]  memwbRd,
    input  wire logic                    exmemMemWrite,
    input  wire logic                    memwbMemWrite,
    output fwdSelT                       fwdA,
    output fwdSelT                       fwdB
);

    // newest producer wins
    // EX/MEM is distance 1, MEM/WB distance 2
    function automatic fwdSelT pickSource(
        input logic [`REG_ADDR_W-1:0] idx,
        input logic                   exWr,
        input logic [`REG_ADDR_W-1:0] exRd,
        input logic                   wbWr,
        input logic [`REG_ADDR_W-1:0] wbRd
    );
        fwdSelT sel;
        sel = FWD_NONE;
        if (exWr && (exRd == idx)) begin
            sel = FWD_EXMEM;
        end else if (wbWr && (wbRd == idx)) begin
            sel = FWD_MEMWB;
        end
        return sel;
    endfunction

    always_comb begin
        fwdA = pickSource(idexRs, exmemRegWrite, exmemRd, memwbRegWrite, memwbRd);
        fwdB = pickSource(idexRt, exmemRegWrite, exmemRd, memwbRegWrite, memwbRd);

        assert ((fwdA != FWD_EXMEM && fwdB != FWD_EXMEM) || exmemRegWrite)
            else $error("EX/MEM forward without regWrite");
        // store entries are never a forwarding source
        assert (!(exmemMemWrite && (fwdA == FWD_EXMEM || fwdB == FWD_EXMEM)))
            else $error("forward from a store in EX/MEM");
        assert (!(memwbMemWrite && (fwdA == FWD_MEMWB || fwdB == FWD_MEMWB)))
            else $error("forward from a store in MEM/WB");
    end

endmodule

`default_nettype wire

//--- hdl/executeDatapath.sv
`default_nettype none
`include "pipe_config.svh"

module executeDatapath
    import pipePkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   arstN,
    input  wire logic [`DATA_W-1:0]     readDataA,
    input  wire logic [`DATA_W-1:0]     readDataB,
    input  wire fwdSelT                 fwdA,
    input  wire fwdSelT                 fwdB,
    input  wire aluOpT                  idexAluOp,
    input  wire logic                   idexUseImm,
    input  wire logic                   idexImmOnly,
    input  wire logic [`DATA_W-1:0]     idexImm,
    output logic [`MEM_ADDR_W-1:0]      memAddr,
    output logic [`DATA_W-1:0]          memWdata,
    output logic [`DATA_W-1:0]          wbData
);

    logic [`DATA_W-1:0] idexOpA;
    logic [`DATA_W-1:0] idexOpB;
    logic [`DATA_W-1:0] opA;
    logic [`DATA_W-1:0] opB;
    logic [`DATA_W-1:0] aluA;
    logic [`DATA_W-1:0] aluB;
    logic [`DATA_W-1:0] aluResult;
    logic [`DATA_W-1:0] exmemResult;
    logic [`DATA_W-1:0] exmemStoreData;
    logic [`DATA_W-1:0] memwbResult;

    // ID/EX operands straight from the register read
    always_ff @(posedge clk) begin
        idexOpA <= readDataA;
        idexOpB <= readDataB;
    end

    // forwarding muxes
    always_comb begin
        case (fwdA)
            FWD_EXMEM: opA = exmemResult;
            FWD_MEMWB: opA = memwbResult;
            default:   opA = idexOpA;
        endcase
        case (fwdB)
            FWD_EXMEM: opB = exmemResult;
            FWD_MEMWB: opB = memwbResult;
            default:   opB = idexOpB;
        endcase
    end

    // lbi zeroes A so the adder passes imm
    assign aluA = idexImmOnly ? '0 : opA;
    // st keeps opB as store data, imm goes to the adder
    assign aluB = idexUseImm ? idexImm : opB;

    always_comb begin
        case (idexAluOp)
            ALU_SUB: aluResult = aluA - aluB;
            ALU_AND: aluResult = aluA & aluB;
            ALU_XOR: aluResult = aluA ^ aluB;
            default: aluResult = aluA + aluB;
        endcase
    end

    // EX/MEM then MEM/WB
    always_ff @(posedge clk) begin
        exmemResult    <= aluResult;
        exmemStoreData <= opB;
        memwbResult    <= exmemResult;
    end

    // address is the low bits of base + offset
    assign memAddr  = exmemResult[`MEM_ADDR_W-1:0];
    assign memWdata = exmemStoreData;
    assign wbData   = memwbResult;

    // unused select code would fall into the register path silently
    assert property (@(posedge clk) disable iff (!arstN)
        (fwdA != 2'b11) && (fwdB != 2'b11))
        else $error("illegal forwarding select");

endmodule

`default_nettype wire

//--- hdl/pipeCore.sv
`default_nettype none
`include "pipe_config.svh"

module pipeCore
    import pipePkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   arstN,
    input  wire logic                   instrValid,
    input  wire logic [`DATA_W-1:0]     instr,
    output logic                        wbValid,
    output logic [`REG_ADDR_W-1:0]      wbReg,
    output logic [`DATA_W-1:0]          wbData,
    output logic                        memWrite,
    output logic [`MEM_ADDR_W-1:0]      memAddr,
    output logic [`DATA_W-1:0]          memWdata
);

    logic [`REG_ADDR_W-1:0] readIdxA;
    logic [`REG_ADDR_W-1:0] readIdxB;
    logic [`DATA_W-1:0]     readDataA;
    logic [`DATA_W-1:0]     readDataB;
    logic [`REG_ADDR_W-1:0] idexRs;
    logic [`REG_ADDR_W-1:0] idexRt;
    aluOpT                  idexAluOp;
    logic                   idexUseImm;
    logic                   idexImmOnly;
    logic [`DATA_W-1:0]     idexImm;
    logic                   exmemRegWrite;
    logic                   exmemMemWrite;
    logic [`REG_ADDR_W-1:0] exmemRd;
    logic                   memwbRegWrite;
    logic                   memwbMemWrite;
    logic [`REG_ADDR_W-1:0] memwbRd;
    fwdSelT                 fwdA;
    fwdSelT                 fwdB;

    // decode and stage control
    pipeControl control0 (
        .clk           (clk),
        .arstN         (arstN),
        .instrValid    (instrValid),
        .instr         (instr),
        .readIdxA      (readIdxA),
        .readIdxB      (readIdxB),
        .idexRs        (idexRs),
        .idexRt        (idexRt),
        .idexAluOp     (idexAluOp),
        .idexUseImm    (idexUseImm),
        .idexImmOnly   (idexImmOnly),
        .idexImm       (idexImm),
        .exmemRegWrite (exmemRegWrite),
        .exmemMemWrite (exmemMemWrite),
        .exmemRd       (exmemRd),
        .memwbRegWrite (memwbRegWrite),
        .memwbMemWrite (memwbMemWrite),
        .memwbRd       (memwbRd),
        .memWrite      (memWrite),
        .wbValid       (wbValid),
        .wbReg         (wbReg)
    );

    // written from MEM/WB
    regFile regFile0 (
        .clk       (clk),
        .arstN     (arstN),
        .readIdxA  (readIdxA),
        .readIdxB  (readIdxB),
        .writeEn   (wbValid),
        .writeIdx  (wbReg),
        .writeData (wbData),
        .readDataA (readDataA),
        .readDataB (readDataB)
    );

    forwardingUnit fwd0 (
        .idexRs        (idexRs),
        .idexRt        (idexRt),
        .exmemRegWrite (exmemRegWrite),
        .exmemRd       (exmemRd),
        .memwbRegWrite (memwbRegWrite),
        .memwbRd       (memwbRd),
        .exmemMemWrite (exmemMemWrite),
        .memwbMemWrite (memwbMemWrite),
        .fwdA          (fwdA),
        .fwdB          (fwdB)
    );

    executeDatapath exec0 (
        .clk         (clk),
        .arstN       (arstN),
        .readDataA   (readDataA),
        .readDataB   (readDataB),
        .fwdA        (fwdA),
        .fwdB        (fwdB),
        .idexAluOp   (idexAluOp),
        .idexUseImm  (idexUseImm),
        .idexImmOnly (idexImmOnly),
        .idexImm     (idexImm),
        .memAddr     (memAddr),
        .memWdata    (memWdata),
        .wbData      (wbData)
    );

endmodule

`default_nettype wire

//--- tb/pipeTbTasks.svh
`ifndef PIPE_TB_TASKS_SVH
`define PIPE_TB_TASKS_SVH

// encoders for the three formats
function automatic logic [`DATA_W-1:0] rType(opcodeT op, int rd, int rs, int rt);
    return {op, 3'(rd), 3'(rs), 3'(rt), 3'b000};
endfunction

function automatic logic [`DATA_W-1:0] iType(opcodeT op, int rd, int rs, int imm);
    return {op, 3'(rd), 3'(rs), 6'(imm)};
endfunction

function automatic logic [`DATA_W-1:0] lbi(int rd, int imm);
    return {OP_LBI, 3'(rd), 1'b0, 8'(imm)};
endfunction

task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
        $display("Fail at time %0t: %s is %h, expected %h", $time, what, got, exp);
        $display("Test failed");
        $fatal(1, "first mismatch");
    end
endtask

// drive one instruction and run it through the shadow model
task automatic issue(input logic [`DATA_W-1:0] ins);
    logic [`REG_ADDR_W-1:0] rd;
    logic [`DATA_W-1:0]     a;
    logic [`DATA_W-1:0]     b;
    logic [`DATA_W-1:0]     imm6;
    logic [`DATA_W-1:0]     res;
    logic                   writes;
    @(posedge clk);
    instrValid <= 1'b1;
    instr      <= ins;
    rd     = ins[11:9];
    a      = shadowRegs[ins[8:6]];
    b      = shadowRegs[ins[5:3]];
    imm6   = {{(`DATA_W-6){ins[5]}}, ins[5:0]};
    writes = 1'b1;
    res    = '0;
    case (ins[15:12])
        OP_ADD:  res = a + b;
        OP_SUB:  res = a - b;
        OP_AND:  res = a & b;
        OP_XOR:  res = a ^ b;
        OP_ADDI: res = a + imm6;
        OP_LBI:  res = {{(`DATA_W-8){ins[7]}}, ins[7:0]};
        // rd names the data register, rs the base
        OP_ST: begin
            writes = 1'b0;
            res    = a + imm6;
            stTagQ.push_back(cyc + 3);
            stAddrQ.push_back(res[`MEM_ADDR_W-1:0]);
            stDataQ.push_back(shadowRegs[rd]);
        end
        // nop and unknown opcodes
        default: writes = 1'b0;
    endcase
    if (writes) begin
        shadowRegs[rd] = res;
        wbTagQ.push_back(cyc + 4);
        wbRegQ.push_back(rd);
        wbDataQ.push_back(res);
    end
endtask

// instr carries junk while valid is low
task automatic bubble();
    @(posedge clk);
    instrValid <= 1'b0;
    instr      <= 16'($random(seed));
endtask

// operands written well ahead of use
task automatic lbiAndAluOps();
    issue(lbi(1, 8'h35));
    issue(lbi(2, -18));
    repeat (3) bubble();
    issue(rType(OP_ADD, 3, 1, 2));
    issue(rType(OP_SUB, 4, 1, 2));
    issue(rType(OP_AND, 5, 1, 2));
    issue(rType(OP_XOR, 6, 1, 2));
    issue(iType(OP_ADDI, 7, 1, -5));
endtask

// back to back, r0 used like any other register
task automatic exMemForwarding();
    issue(lbi(0, 7));
    issue(iType(OP_ADDI, 0, 0, 3));
    issue(rType(OP_ADD, 1, 2, 0));
    // distinct operands so a stale value shows in the result
    issue(rType(OP_SUB, 2, 0, 1));
    issue(rType(OP_XOR, 3, 2, 1));
endtask

task automatic memWbForwarding();
    issue(lbi(3, 100));
    issue(lbi(4, -20));
    issue(rType(OP_ADD, 5, 3, 4));
    // both producers hit r6, newer one must win
    issue(lbi(6, 1));
    issue(lbi(6, 2));
    issue(rType(OP_ADD, 7, 6, 6));
    issue(lbi(1, 9));
    bubble();
    issue(rType(OP_AND, 2, 1, 1));
endtask

// producer still in MEM/WB during the read
task automatic regFileBypass();
    issue(lbi(2, -100));
    issue(lbi(4, 1));
    issue(lbi(5, 2));
    issue(rType(OP_ADD, 1, 2, 5));
    issue(lbi(0, 77));
    repeat (2) bubble();
    issue(iType(OP_ADDI, 3, 0, 1));
endtask

task automatic forwardedStores();
    issue(lbi(1, 8'h40));
    issue(lbi(2, -3));
    issue(iType(OP_ST, 2, 1, 5));
    issue(iType(OP_ADDI, 1, 1, 1));
    issue(iType(OP_ST, 1, 1, -8));
    bubble();
endtask

// mixed stream with bubbles, nops and unknown opcodes
task automatic randomMix(input int count);
    int                 r;
    logic [`DATA_W-1:0] ins;
    for (int n = 0; n < count; n++) begin
        r = $random(seed);
        if (r[23:20] == 4'h0) begin
            bubble();
        end else begin
            ins     = r[15:0];
            ins[15] = (r[19:16] == 4'h0);
            issue(ins);
        end
    end
endtask

`endif

//--- tb/pipeCoreTb.sv
`default_nettype none
`include "pipe_config.svh"

module pipeCoreTb
    import pipePkg::*;
    ();

    localparam int RESET_CYCLES   = 8;
    // upper bound on directed slots, instructions plus bubbles
    localparam int DIRECTED_SLOTS = 60;
    localparam int RANDOM_LEN     = 64;
    localparam int DRAIN_SLOTS    = 8;
    // 4 time units per cycle
    localparam int TIMEOUT =
        (RESET_CYCLES + DIRECTED_SLOTS + RANDOM_LEN + DRAIN_SLOTS + 20) * 4;

    // starts low so time 0 carries no clock edge
    logic                   clk = 1'b0;
    logic                   arstN;
    logic                   instrValid;
    logic [`DATA_W-1:0]     instr;
    logic                   wbValid;
    logic [`REG_ADDR_W-1:0] wbReg;
    logic [`DATA_W-1:0]     wbData;
    logic                   memWrite;
    logic [`MEM_ADDR_W-1:0] memAddr;
    logic [`DATA_W-1:0]     memWdata;

    // negedge count, expected outputs are tagged with it
    int                     cyc;
    integer                 seed;
    logic [`DATA_W-1:0]     shadowRegs [`NUM_REGS];

    // expected write-back and store triples
    int                     wbTagQ [$];
    logic [`REG_ADDR_W-1:0] wbRegQ [$];
    logic [`DATA_W-1:0]     wbDataQ [$];
    int                     stTagQ [$];
    logic [`MEM_ADDR_W-1:0] stAddrQ [$];
    logic [`DATA_W-1:0]     stDataQ [$];

    `include "pipeTbTasks.svh"

    pipeCore dut0 (
        .clk        (clk),
        .arstN      (arstN),
        .instrValid (instrValid),
        .instr      (instr),
        .wbValid    (wbValid),
        .wbReg      (wbReg),
        .wbData     (wbData),
        .memWrite   (memWrite),
        .memAddr    (memAddr),
        .memWdata   (memWdata)
    );

    always #2 clk = ~clk;

    // outputs sampled mid-cycle, strobes must be low unless expected
    always @(negedge clk) begin
        cyc = cyc + 1;
        if (wbTagQ.size() > 0 && wbTagQ[0] == cyc) begin
            checkEq(32'(wbValid), 32'd1, "wbValid");
            checkEq(32'(wbReg), 32'(wbRegQ[0]), "wbReg");
            checkEq(32'(wbData), 32'(wbDataQ[0]), "wbData");
            wbTagQ.delete(0);
            wbRegQ.delete(0);
            wbDataQ.delete(0);
        end else begin
            checkEq(32'(wbValid), 32'd0, "idle wbValid");
        end
        if (stTagQ.size() > 0 && stTagQ[0] == cyc) begin
            checkEq(32'(memWrite), 32'd1, "memWrite");
            checkEq(32'(memAddr), 32'(stAddrQ[0]), "memAddr");
            checkEq(32'(memWdata), 32'(stDataQ[0]), "memWdata");
            stTagQ.delete(0);
            stAddrQ.delete(0);
            stDataQ.delete(0);
        end else begin
            checkEq(32'(memWrite), 32'd0, "idle memWrite");
        end
    end

    // watchdog
    initial begin
        #(TIMEOUT);
        $display("watchdog expired before the test sequence finished");
        $display("Test failed");
        $fatal(1, "timeout");
    end

    initial begin
        arstN      = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        cyc        = 0;
        seed       = 32'h00681737;
        for (int i = 0; i < `NUM_REGS; i++) begin
            shadowRegs[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        arstN <= 1'b1;

        lbiAndAluOps();
        exMemForwarding();
        memWbForwarding();
        regFileBypass();
        forwardedStores();
        randomMix(RANDOM_LEN);
        repeat (DRAIN_SLOTS) bubble();

        if (wbTagQ.size() != 0 || stTagQ.size() != 0) begin
            $display("expected outputs never appeared at the end of the run");
            $display("Test failed");
            $fatal(1, "outputs missing");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+hdl
+incdir+tb
hdl/pipePkg.sv
hdl/pipeControl.sv
hdl/regFile.sv
hdl/forwardingUnit.sv
hdl/executeDatapath.sv
hdl/pipeCore.sv
tb/pipeCoreTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= pipeCoreTb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

BIN     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard hdl/*.sv hdl/*.svh tb/*.sv tb/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "Test passed" $(LOG); then echo "simulation ended early"; exit 1; fi
	@echo "simulation ok"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
